// ==== verilog/frontEnd_cfg.svh ====
// Console front end configuration
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// Word widths
`define WORD36_BITS 36
`define FIELD_BITS 16
`define ADDR_BITS 18
`define FUNC_BITS 7

// Separators of an ASCIIized load line
`define CHAR_COMMA 8'h2C
`define CHAR_SPACE 8'h20
`define CHAR_LF 8'h0A
`define CHAR_CR 8'h0D

// Record letter of a PDP-10 load line
`define RECORD_T 8'h54

// Diagnostic bus phase lengths in clock cycles
`define FUNC_STROBE_CYCLES 18
`define WRITE_STROBE_CYCLES 3
`define WRITE_DRIVE_CYCLES 4
// Cycle at whose end the read data is taken
`define READ_SAMPLE_CYCLE 2

`endif

// ==== verilog/frontEndPkg.sv ====
// Console front end types
`include "frontEnd_cfg.svh"

package frontEndPkg;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  // Bus or memory word, bit 35 is PDP-10 bit 0
  typedef logic [`WORD36_BITS-1:0] word36T;
  // Decoded PDP-11 field word
  typedef logic [`FIELD_BITS-1:0] fieldWordT;
  typedef logic [`ADDR_BITS-1:0] pdpAddrT;
  typedef logic [7:0] asciiCharT;
  typedef logic [`FUNC_BITS-1:0] diagFuncT;

  ////////////////////////////////////////
  // State machines and command kinds
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    diagWrite,
    diagFunc,
    diagRead
  } diagKindT;

  // Sequencer phases
  typedef enum logic [1:0] {
    idle,
    strobing,
    driveTail
  } seqStateT;

  // Loader position inside a load line
  typedef enum logic [1:0] {
    wordCount,
    address,
    data,
    skip
  } loadStateT;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // Diagnostic command, 45 bits
  typedef struct packed {
    diagKindT kind;
    diagFuncT func;
    word36T data;
  } diagCmdT;

  // What the front end puts on the diagnostic bus, 45 bits
  typedef struct packed {
    diagFuncT func;
    logic diagStrobe;
    logic driving;
    word36T data;
  } ebusDriveT;

  // One finished field of a load line, 25 bits
  typedef struct packed {
    fieldWordT word;
    asciiCharT recType;
    logic lineEnd;
  } fieldEventT;

endpackage

// ==== verilog/asciiWordDecoder.sv ====
// ASCIIized field decoder
`timescale 1ns/100ps
`include "frontEnd_cfg.svh"

module asciiWordDecoder (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    charValid,
  input  frontEndPkg::asciiCharT  charIn,
  output logic                    fieldValid,
  output frontEndPkg::fieldEventT fieldEvent
);

  // Set once the record letter of the current line is taken
  logic haveType;
  frontEndPkg::asciiCharT heldType;
  frontEndPkg::fieldWordT acc;

  logic isSep;
  logic isLf;
  logic isBlank;

  // Character classes
  always_comb begin
    isLf = (charIn == `CHAR_LF);
    isSep = isLf || (charIn == `CHAR_COMMA);
    isBlank = (charIn == `CHAR_SPACE) || (charIn == `CHAR_CR);
  end

  ////////////////////////////////////////
  // Line position and accumulator
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haveType <= 1'b0;
      acc <= '0;
      fieldValid <= 1'b0;
    end else begin
      fieldValid <= 1'b0;
      if (charValid) begin
        if (isSep) begin
          fieldValid <= 1'b1;
          acc <= '0;
          // Next character starts a new line
          if (isLf) begin
            haveType <= 1'b0;
          end
        end else if (!isBlank) begin
          if (!haveType) begin
            haveType <= 1'b1;
          end else begin
            // Six more bits in, oldest bits fall off the top
            acc <= {acc[`FIELD_BITS-7:0], charIn[5:0]};
          end
        end
      end
    end
  end

  // Record letter and finished field, no reset needed
  always_ff @(posedge clk) begin
    if (charValid && !isSep && !isBlank && !haveType) begin
      heldType <= charIn;
    end
    if (charValid && isSep) begin
      fieldEvent.word <= acc;
      fieldEvent.recType <= heldType;
      // Field before LF is the line checksum
      fieldEvent.lineEnd <= isLf;
    end
  end

endmodule

// ==== verilog/a10LineLoader.sv ====
// A10 load line loader
`timescale 1ns/100ps
`include "frontEnd_cfg.svh"

module a10LineLoader (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    fieldValid,
  input  frontEndPkg::fieldEventT fieldEvent,
  output logic                    memWrite,
  output frontEndPkg::pdpAddrT    memAddr,
  output frontEndPkg::word36T     memData,
  output logic                    startValid,
  output frontEndPkg::pdpAddrT    startAddr,
  output logic                    checksumError
);

  frontEndPkg::loadStateT state;
  // Position inside a data triplet
  logic [1:0] tripIdx;
  logic [`FIELD_BITS-3:0] wordsDone;
  frontEndPkg::fieldWordT sum;

  // Line header and partial data word
  logic [`FIELD_BITS-3:0] wcReg;
  logic [1:0] addrHi;
  frontEndPkg::pdpAddrT baseAddr;
  frontEndPkg::fieldWordT w0;
  frontEndPkg::fieldWordT w1;

  logic isT;
  logic midLine;
  logic lineDone;
  logic writeNow;
  frontEndPkg::fieldWordT sumNext;

  always_comb begin
    isT = (fieldEvent.recType == `RECORD_T);
    midLine = fieldValid && !fieldEvent.lineEnd;
    lineDone = fieldValid && fieldEvent.lineEnd;
    // Third field of a triplet that is still inside the word count
    writeNow = midLine && (state == frontEndPkg::data) && (tripIdx == 2'd2)
               && (wordsDone < wcReg);
    // Negated checksum makes the line total zero
    sumNext = sum + fieldEvent.word;
  end

  ////////////////////////////////////////
  // Line walk
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= frontEndPkg::wordCount;
      tripIdx <= '0;
      wordsDone <= '0;
      sum <= '0;
      memWrite <= 1'b0;
      startValid <= 1'b0;
      checksumError <= 1'b0;
    end else begin
      memWrite <= writeNow;
      checksumError <= 1'b0;
      if (lineDone) begin
        if (state != frontEndPkg::skip) begin
          checksumError <= (sumNext != '0);
          // Transfer line carries the program start
          if (state == frontEndPkg::data && wcReg == '0) begin
            startValid <= 1'b1;
          end
        end
        state <= frontEndPkg::wordCount;
        tripIdx <= '0;
        wordsDone <= '0;
        sum <= '0;
      end else if (midLine) begin
        sum <= sumNext;
        case (state)
          frontEndPkg::wordCount: begin
            state <= isT ? frontEndPkg::address : frontEndPkg::skip;
          end
          frontEndPkg::address: state <= frontEndPkg::data;
          frontEndPkg::data: begin
            tripIdx <= (tripIdx == 2'd2) ? 2'd0 : tripIdx + 2'd1;
            if (writeNow) begin
              wordsDone <= wordsDone + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Header fields and data assembly
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (midLine && state == frontEndPkg::wordCount) begin
      // High byte bits carry address bits 17 and 16
      wcReg <= fieldEvent.word[`FIELD_BITS-3:0];
      addrHi <= fieldEvent.word[`FIELD_BITS-1:`FIELD_BITS-2];
    end
    if (midLine && state == frontEndPkg::address) begin
      baseAddr <= {addrHi, fieldEvent.word};
    end
    if (midLine && state == frontEndPkg::data && tripIdx == 2'd0) begin
      w0 <= fieldEvent.word;
    end
    if (midLine && state == frontEndPkg::data && tripIdx == 2'd1) begin
      w1 <= fieldEvent.word;
    end
    if (writeNow) begin
      memAddr <= baseAddr + `ADDR_BITS'(wordsDone);
      // PDP-10 bits 0-3, 4-19, 20-35
      memData <= {fieldEvent.word[3:0], w1, w0};
    end
    if (lineDone && state == frontEndPkg::data && wcReg == '0) begin
      startAddr <= baseAddr;
    end
  end

endmodule

// ==== verilog/diagSequencer.sv ====
// Diagnostic bus sequencer
`timescale 1ns/100ps
`include "frontEnd_cfg.svh"

module diagSequencer (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   cmdValid,
  input  frontEndPkg::diagCmdT   cmd,
  output logic                   busy,
  output frontEndPkg::ebusDriveT ebus,
  input  frontEndPkg::word36T    ebusData,
  output logic                   readDone,
  output frontEndPkg::word36T    readResult
);

  // Counter spans the longest phase
  localparam int CNT_BITS = $clog2(`FUNC_STROBE_CYCLES);

  frontEndPkg::seqStateT state;
  logic [CNT_BITS-1:0] cnt;
  // Command held for the whole operation
  frontEndPkg::diagCmdT cmdReg;

  logic accept;
  logic [CNT_BITS-1:0] strobeLast;
  logic isWrite;
  logic isRead;

  always_comb begin
    accept = cmdValid && (state == frontEndPkg::idle);
    isWrite = (cmdReg.kind == frontEndPkg::diagWrite);
    isRead = (cmdReg.kind == frontEndPkg::diagRead);
    // Last strobe cycle per kind
    case (cmdReg.kind)
      frontEndPkg::diagFunc: strobeLast = CNT_BITS'(`FUNC_STROBE_CYCLES - 1);
      frontEndPkg::diagRead: strobeLast = CNT_BITS'(`READ_SAMPLE_CYCLE);
      default: strobeLast = CNT_BITS'(`WRITE_STROBE_CYCLES - 1);
    endcase
  end

  ////////////////////////////////////////
  // Phase control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= frontEndPkg::idle;
      cnt <= '0;
      readDone <= 1'b0;
    end else begin
      readDone <= 1'b0;
      case (state)
        frontEndPkg::idle: begin
          if (accept) begin
            state <= frontEndPkg::strobing;
            cnt <= '0;
          end
        end
        frontEndPkg::strobing: begin
          cnt <= cnt + 1'b1;
          // Read word is taken at the end of the sample cycle
          if (isRead && cnt == CNT_BITS'(`READ_SAMPLE_CYCLE)) begin
            readDone <= 1'b1;
          end
          if (cnt == strobeLast) begin
            state <= isWrite ? frontEndPkg::driveTail : frontEndPkg::idle;
          end
        end
        frontEndPkg::driveTail: begin
          // Data stays on the bus past the strobe
          cnt <= cnt + 1'b1;
          if (cnt == CNT_BITS'(`WRITE_DRIVE_CYCLES - 1)) begin
            state <= frontEndPkg::idle;
          end
        end
        default: state <= frontEndPkg::idle;
      endcase
    end
  end

  // Command and read data registers
  always_ff @(posedge clk) begin
    if (accept) begin
      cmdReg <= cmd;
    end
    if (state == frontEndPkg::strobing && isRead
        && cnt == CNT_BITS'(`READ_SAMPLE_CYCLE)) begin
      readResult <= ebusData;
    end
  end

  ////////////////////////////////////////
  // Bus outputs
  ////////////////////////////////////////

  always_comb begin
    busy = (state != frontEndPkg::idle);
    ebus.func = cmdReg.func;
    ebus.data = cmdReg.data;
    ebus.diagStrobe = (state == frontEndPkg::strobing);
    // Only a write drives the data lines
    ebus.driving = busy && isWrite;
  end

endmodule

// ==== verilog/frontEnd.sv ====
// Console front end top level
`timescale 1ns/100ps

module frontEnd (
  input  logic                   clk,
  input  logic                   arstN,
  // Load line character stream
  input  logic                   charValid,
  input  frontEndPkg::asciiCharT charIn,
  output logic                   memWrite,
  output frontEndPkg::pdpAddrT   memAddr,
  output frontEndPkg::word36T    memData,
  output logic                   startValid,
  output frontEndPkg::pdpAddrT   startAddr,
  output logic                   checksumError,
  // Diagnostic commands and bus
  input  logic                   cmdValid,
  input  frontEndPkg::diagCmdT   cmd,
  output logic                   busy,
  output frontEndPkg::ebusDriveT ebus,
  input  frontEndPkg::word36T    ebusData,
  output logic                   readDone,
  output frontEndPkg::word36T    readResult
);

  // Decoder to loader
  logic fieldValid;
  frontEndPkg::fieldEventT fieldEvent;

  asciiWordDecoder decoder_inst (
    .clk        (clk),
    .arstN      (arstN),
    .charValid  (charValid),
    .charIn     (charIn),
    .fieldValid (fieldValid),
    .fieldEvent (fieldEvent)
  );

  a10LineLoader loader_inst (
    .clk           (clk),
    .arstN         (arstN),
    .fieldValid    (fieldValid),
    .fieldEvent    (fieldEvent),
    .memWrite      (memWrite),
    .memAddr       (memAddr),
    .memData       (memData),
    .startValid    (startValid),
    .startAddr     (startAddr),
    .checksumError (checksumError)
  );

  diagSequencer sequencer_inst (
    .clk        (clk),
    .arstN      (arstN),
    .cmdValid   (cmdValid),
    .cmd        (cmd),
    .busy       (busy),
    .ebus       (ebus),
    .ebusData   (ebusData),
    .readDone   (readDone),
    .readResult (readResult)
  );

endmodule

// ==== verification/frontEnd_checker.sv ====
// Diagnostic bus protocol checker
`timescale 1ns/100ps

module frontEnd_checker (
  input logic                   clk,
  input logic                   arstN,
  input logic                   cmdValid,
  input frontEndPkg::diagCmdT   cmd,
  input logic                   busy,
  input frontEndPkg::ebusDriveT ebus,
  input logic                   readDone
);

  // Failed assertions, read back at the end of the run
  int failCount = 0;

  // Kind of the last accepted command, taken from the command port
  frontEndPkg::diagKindT heldKind;

  always_ff @(posedge clk) begin
    if (cmdValid && !busy) begin
      heldKind <= cmd.kind;
    end
  end

  ////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////

  // Write data is on the bus for the whole strobe
  writeDrive: assert property (@(posedge clk) disable iff (!arstN)
    (ebus.diagStrobe && heldKind == frontEndPkg::diagWrite) |-> ebus.driving)
    else begin
      failCount++;
      $error("Write strobe seen without the bus being driven");
    end

  // Strobe only inside busy, and it starts the cycle after acceptance
  strobeBusy: assert property (@(posedge clk) disable iff (!arstN)
    ebus.diagStrobe |-> busy && ($past(ebus.diagStrobe) || $past(cmdValid && !busy)))
    else begin
      failCount++;
      $error("Strobe seen while idle or without an accepted command");
    end

  // Last accepted command must be a read when the pulse comes
  readOnly: assert property (@(posedge clk) disable iff (!arstN)
    readDone |-> heldKind == frontEndPkg::diagRead)
    else begin
      failCount++;
      $error("Read done pulsed after a command that was not a read");
    end

endmodule

// ==== verification/frontEndTb.sv ====
// Console front end testbench
`timescale 1ns/100ps
`include "frontEnd_cfg.svh"

module frontEndTb;

  localparam int PAT_DEPTH = 64;

  logic clk;
  logic arstN;
  logic charValid;
  frontEndPkg::asciiCharT charIn;
  logic memWrite;
  frontEndPkg::pdpAddrT memAddr;
  frontEndPkg::word36T memData;
  logic startValid;
  frontEndPkg::pdpAddrT startAddr;
  logic checksumError;
  logic cmdValid;
  frontEndPkg::diagCmdT cmd;
  logic busy;
  frontEndPkg::ebusDriveT ebus;
  frontEndPkg::word36T ebusData;
  logic readDone;
  frontEndPkg::word36T readResult;

  // Pattern entries, kind in the top byte
  logic [95:0] pat [PAT_DEPTH];
  int patCount;
  int mismatchCount;
  int failCount;
  int cycle;
  int cycleLimit = 1000000;
  int negCount;
  integer seed;

  // Expected results in order of arrival
  frontEndPkg::pdpAddrT expWrAddr[$];
  frontEndPkg::word36T expWrData[$];
  frontEndPkg::word36T expRead[$];
  logic expFlag[$];
  // Falling edge at which a line's checksum flag is due
  int lfDue[$];
  logic expStartSeen;
  frontEndPkg::pdpAddrT expStart;

  frontEnd frontEnd_inst (.*);

  bind diagSequencer frontEnd_checker checker_inst (
    .clk      (clk),
    .arstN    (arstN),
    .cmdValid (cmdValid),
    .cmd      (cmd),
    .busy     (busy),
    .ebus     (ebus),
    .readDone (readDone)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic compareWord36(input string name, input frontEndPkg::word36T got,
                               input frontEndPkg::word36T exp);
    if (got !== exp) begin
      mismatchCount++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compareAddr(input string name, input frontEndPkg::pdpAddrT got,
                             input frontEndPkg::pdpAddrT exp);
    if (got !== exp) begin
      mismatchCount++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compareFunc(input string name, input frontEndPkg::diagFuncT got,
                             input frontEndPkg::diagFuncT exp);
    if (got !== exp) begin
      mismatchCount++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compareFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatchCount++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Outputs are sampled at the falling edge where they are settled
  always @(negedge clk) begin
    negCount = negCount + 1;
    if (arstN) begin
      if (memWrite) begin
        if (expWrAddr.size() == 0) begin
          failCount++;
          $display("Unexpected memory write to address %h", memAddr);
        end else begin
          compareAddr("memAddr", memAddr, expWrAddr.pop_front());
          compareWord36("memData", memData, expWrData.pop_front());
        end
      end
      if (readDone) begin
        if (expRead.size() == 0) begin
          failCount++;
          $display("Read completed with no read expected");
        end else begin
          compareWord36("readResult", readResult, expRead.pop_front());
        end
      end
      // LF accepted next edge, field event one edge later, flag the edge after
      if (lfDue.size() != 0 && lfDue[0] == negCount) begin
        lfDue.pop_front();
        if (expFlag.size() == 0) begin
          failCount++;
          $display("Line ended with no checksum result listed");
        end else begin
          compareFlag("checksumError", checksumError, expFlag.pop_front());
        end
      end else if (checksumError) begin
        failCount++;
        $display("Checksum error pulsed outside a line end");
      end
      if (charValid && charIn == `CHAR_LF) begin
        lfDue.push_back(negCount + 2);
      end
    end
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > cycleLimit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Up to eleven characters, first in the top byte, zero bytes skipped
  task automatic feedChars(input logic [87:0] payload);
    logic [7:0] ch;
    for (int i = 10; i >= 0; i--) begin
      ch = payload[i*8 +: 8];
      if (ch != 8'h00) begin
        @(posedge clk);
        #2;
        charValid = 1'b1;
        charIn = ch;
      end
    end
  endtask

  // One bus operation, windows checked cycle by cycle
  task automatic runCommand(input logic [87:0] payload);
    frontEndPkg::diagCmdT c;
    frontEndPkg::word36T rdVal;
    logic [63:0] noise;
    int busLen;
    int strobeLen;
    c.kind = frontEndPkg::diagKindT'(payload[81:80]);
    c.func = payload[78:72];
    c.data = payload[71:36];
    rdVal = payload[35:0];
    busLen = `WRITE_DRIVE_CYCLES;
    strobeLen = `WRITE_STROBE_CYCLES;
    if (c.kind == frontEndPkg::diagFunc) begin
      busLen = `FUNC_STROBE_CYCLES;
      strobeLen = `FUNC_STROBE_CYCLES;
    end else if (c.kind == frontEndPkg::diagRead) begin
      busLen = `READ_SAMPLE_CYCLE + 1;
      strobeLen = `READ_SAMPLE_CYCLE + 1;
    end
    @(posedge clk);
    #2;
    charValid = 1'b0;
    cmd = c;
    cmdValid = 1'b1;
    for (int k = 0; k <= busLen; k++) begin
      @(posedge clk);
      #2;
      cmdValid = 1'b0;
      noise = {$random(seed), $random(seed)};
      ebusData = noise[35:0];
      if (c.kind == frontEndPkg::diagRead && k == `READ_SAMPLE_CYCLE) begin
        ebusData = rdVal;
      end
      // A write offered mid function must be dropped
      if (c.kind == frontEndPkg::diagFunc && k == 4) begin
        cmdValid = 1'b1;
        cmd.kind = frontEndPkg::diagWrite;
        cmd.data = ~c.data;
      end
      @(negedge clk);
      compareFlag("busy", busy, k < busLen);
      compareFlag("ebus.diagStrobe", ebus.diagStrobe, k < strobeLen);
      compareFlag("ebus.driving", ebus.driving,
                  c.kind == frontEndPkg::diagWrite && k < busLen);
      compareFlag("readDone", readDone, c.kind == frontEndPkg::diagRead && k == busLen);
      if (k < busLen) begin
        compareFunc("ebus.func", ebus.func, c.func);
        if (c.kind == frontEndPkg::diagWrite) begin
          compareWord36("ebus.data", ebus.data, c.data);
        end
      end
    end
  endtask

  initial begin
    int assertFails;
    int total;
    seed = 32'h7ea385f1;
    arstN = 1'b0;
    charValid = 1'b0;
    charIn = '0;
    cmdValid = 1'b0;
    cmd = '0;
    ebusData = '0;
    expStartSeen = 1'b0;
    expStart = '0;
    for (int i = 0; i < PAT_DEPTH; i++) begin
      pat[i] = '0;
    end
    $readmemh("verification/frontEnd_patterns.txt", pat);
    patCount = 0;
    while (patCount < PAT_DEPTH && pat[patCount][95:88] != 8'h00) begin
      patCount++;
    end
    cycleLimit = patCount * 4 + 200;

    // Expected results first, so their place in the file does not matter
    for (int i = 0; i < patCount; i++) begin
      case (pat[i][95:88])
        8'h03: begin
          expWrAddr.push_back(pat[i][53:36]);
          expWrData.push_back(pat[i][35:0]);
        end
        8'h04: begin
          expStartSeen = 1'b1;
          expStart = pat[i][17:0];
        end
        8'h05: expFlag.push_back(pat[i][0]);
        8'h06: expRead.push_back(pat[i][35:0]);
        default: ;
      endcase
    end

    repeat (10) @(posedge clk);
    #2;
    arstN = 1'b1;

    for (int i = 0; i < patCount; i++) begin
      if (pat[i][95:88] == 8'h01) begin
        feedChars(pat[i][87:0]);
      end else if (pat[i][95:88] == 8'h02) begin
        runCommand(pat[i][87:0]);
      end else if (pat[i][95:88] == 8'h04) begin
        // Lines before the transfer line carry no start address
        compareFlag("startValid", startValid, 1'b0);
      end
    end
    @(posedge clk);
    #2;
    charValid = 1'b0;
    while (lfDue.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);

    if (expWrAddr.size() != 0) begin
      failCount++;
      $display("%0d expected memory writes never happened", expWrAddr.size());
    end
    if (expRead.size() != 0) begin
      failCount++;
      $display("%0d expected reads never completed", expRead.size());
    end
    if (expFlag.size() != 0) begin
      failCount++;
      $display("%0d checksum results were listed for lines never fed", expFlag.size());
    end
    compareFlag("startValid", startValid, expStartSeen);
    if (expStartSeen) begin
      compareAddr("startAddr", startAddr, expStart);
    end

    assertFails = frontEnd_inst.sequencer_inst.checker_inst.failCount;
    total = mismatchCount + failCount + assertFails;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatchCount, failCount, assertFails);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/frontEnd_patterns.txt ====
// Columns: kind_b1_b2_then nine and nine hex digits, 96 bits per entry
// 01 chars (11 bytes, zero skipped), 02 cmd kind_func_data_busData, 03 write addr_data,
// 04 start addr, 05 checksum flag, 06 read result
// T line, two words at 20100
01_54_20_48_40_42_2C_40_44_40_2C_46
01_5E_49_2C_42_4D_45_2C_40_40_41_2C
01_4A_66_47_2C_4E_77_4B_2C_40_40_4F
01_2C_45_73_4E_0D_0A_00_00_00_00_00
03_00_00_000020100_123456789
03_00_00_000020101_FEDCBA987
05_00_00_000000000_000000000
// Transfer line, start at 10400
01_54_20_44_40_40_2C_40_50_40_2C_4B
01_70_40_0D_0A_00_00_00_00_00_00_00
04_00_00_000000000_000010400
05_00_00_000000000_000000000
// One word at 200 with a bad checksum and empty fields
01_54_20_40_40_41_2C_40_48_40_2C_40
01_40_6A_2C_2C_2C_4F_77_54_0D_0A_00
03_00_00_000000200_00000002A
05_00_00_000000000_000000001
// Line of another type is skipped
01_5A_20_40_40_41_2C_40_40_42_2C_40
01_40_43_0D_0A_00_00_00_00_00_00_00
05_00_00_000000000_000000000
// Diagnostic write, function, read
02_00_31_ABCDE0123_000000000
02_01_67_000000000_000000000
02_02_10_000000000_5A5A5A5A5
06_00_00_000000000_5A5A5A5A5

// ==== vlog.f ====
+incdir+verilog
verilog/frontEndPkg.sv
verilog/asciiWordDecoder.sv
verilog/a10LineLoader.sv
verilog/diagSequencer.sv
verilog/frontEnd.sv
verification/frontEnd_checker.sv
verification/frontEndTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the console front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module frontEndTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/VfrontEndTb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
